/* include/power_macros.svh */
`ifndef POWER_MACROS_SVH
`define POWER_MACROS_SVH

// ####################
// power subsystem sizing
// ####################

`define PWR_NO_MEMS      3 // memories that take part in pausing
`define PWR_NO_GPIOS     2
`define PWR_GPIO_WIDTH   8 // pins per port
`define PWR_FUNC_WIDTH   2 // alternate function select bits per pin
`define PWR_SRST_CYCLES  4 // soft reset stretch after reset release

`define PWR_CFG_AW       3 // port index in the upper bits, field in the lower two
`define PWR_CFG_DW       16

// total pin count over all ports
`define PWR_NO_PINS      (`PWR_NO_GPIOS * `PWR_GPIO_WIDTH)

`endif

/* source/power_pkg.sv */
`default_nettype none

`include "power_macros.svh"

package power_pkg;

    // ####################
    // pad and config types
    // ####################

    typedef struct packed {
        logic o;     // value driven when the pin is an output
        logic mode;  // 1 selects output
        logic otype; // 1 selects open drain
    } io_pad_t;

    typedef struct packed {
        logic                   we;    // one cycle write strobe
        logic [`PWR_CFG_AW-1:0] addr;  // also the read-back address
        logic [`PWR_CFG_DW-1:0] wdata;
    } cfg_req_t;

    // ####################
    // sequencer states
    // ####################

    typedef enum logic [1:0] {
        RUN,
        DRAIN,
        PAUSED,
        RESUME
    } pause_state_e;

endpackage

`default_nettype wire

/* source/pad_sync.sv */
`timescale 1ns/1ps
`default_nettype none

module pad_sync #(
    parameter type payload_t = logic
) (
    input  wire logic     clk_i,
    input  wire logic     rst_n_i,
    input  wire payload_t d_i,
    output payload_t      q_o
);

    payload_t meta_q; // first stage may go metastable

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            meta_q <= '0;
            q_o    <= '0;
        end else begin
            meta_q <= d_i;
            q_o    <= meta_q;
        end
    end

endmodule

`default_nettype wire

/* source/pause_seq.sv */
`timescale 1ns/1ps
`default_nettype none

`include "power_macros.svh"

module pause_seq (
    input  wire logic                    clk_i,
    input  wire logic                    rst_n_i,
    input  wire logic                    pause_req_i,
    input  wire logic [`PWR_NO_MEMS-1:0] mem_ack_sync_i,
    output logic [`PWR_NO_MEMS-1:0]      mem_pause_req_o,
    output logic [`PWR_NO_MEMS-1:0]      mem_srst_o,
    output logic                         pause_ack_o
);

    localparam int CNT_W = $clog2(`PWR_SRST_CYCLES + 1);

    power_pkg::pause_state_e state_q;
    power_pkg::pause_state_e state_d;

    logic             ack_q;
    logic             all_ack;
    logic             none_ack;
    logic [CNT_W-1:0] srst_cnt_q;

    assign all_ack  = &mem_ack_sync_i;
    assign none_ack = ~|mem_ack_sync_i;

    // ####################
    // pause handshake
    // ####################

    always_comb begin
        state_d = state_q;
        case (state_q)
            power_pkg::RUN: begin
                if (pause_req_i) begin
                    state_d = power_pkg::DRAIN;
                end
            end
            power_pkg::DRAIN: begin
                if (all_ack) begin
                    state_d = power_pkg::PAUSED;
                end else if (!pause_req_i) begin
                    state_d = power_pkg::RESUME; // request withdrawn before all memories stopped
                end
            end
            power_pkg::PAUSED: begin
                if (!pause_req_i) begin
                    state_d = power_pkg::RESUME;
                end
            end
            default: begin
                if (none_ack) begin
                    state_d = power_pkg::RUN;
                end
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q         <= power_pkg::RUN;
            ack_q           <= 1'b0;
            mem_pause_req_o <= '0;
        end else begin
            state_q         <= state_d;
            ack_q           <= (state_d == power_pkg::PAUSED) ||
                               (ack_q && (state_d != power_pkg::RUN)); // held through RESUME
            mem_pause_req_o <= {`PWR_NO_MEMS{pause_req_i}};
        end
    end

    assign pause_ack_o = ack_q;

    // ####################
    // soft reset stretch
    // ####################

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            srst_cnt_q <= CNT_W'(`PWR_SRST_CYCLES);
        end else if (srst_cnt_q != '0) begin
            srst_cnt_q <= srst_cnt_q - 1'b1;
        end
    end

    assign mem_srst_o = {`PWR_NO_MEMS{srst_cnt_q != '0}};

endmodule

`default_nettype wire

/* source/gpio_bank.sv */
`timescale 1ns/1ps
`default_nettype none

`include "power_macros.svh"

module gpio_bank (
    input  wire logic                                     clk_i,
    input  wire logic                                     rst_n_i,
    input  wire power_pkg::cfg_req_t                      cfg_i,
    input  wire logic                                     paused_i,
    input  wire logic [`PWR_NO_PINS-1:0]                  pins_sync_i,
    output power_pkg::io_pad_t [`PWR_NO_PINS-1:0]         pads_o,
    output logic [`PWR_NO_PINS-1:0][`PWR_FUNC_WIDTH-1:0]  func_o,
    output logic [`PWR_CFG_DW-1:0]                        cfg_rdata_o
);

    localparam int GW = `PWR_GPIO_WIDTH;
    localparam int FW = `PWR_FUNC_WIDTH;
    localparam int PW = `PWR_CFG_AW - 2;

    logic [`PWR_NO_GPIOS-1:0][GW-1:0]    out_q;
    logic [`PWR_NO_GPIOS-1:0][GW-1:0]    mode_q;
    logic [`PWR_NO_GPIOS-1:0][GW-1:0]    otype_q;
    logic [`PWR_NO_GPIOS-1:0][GW*FW-1:0] func_q;

    logic [PW-1:0] port_idx;
    logic [1:0]    field;

    assign port_idx = cfg_i.addr[`PWR_CFG_AW-1:2];
    assign field    = cfg_i.addr[1:0];

    // ####################
    // config registers
    // ####################

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            out_q   <= '0;
            mode_q  <= '0;
            otype_q <= '0;
            func_q  <= '0;
        end else if (cfg_i.we && !paused_i) begin // frozen while paused
            case (field)
                2'd0: out_q[port_idx]   <= cfg_i.wdata[GW-1:0];
                2'd1: mode_q[port_idx]  <= cfg_i.wdata[GW-1:0];
                2'd2: otype_q[port_idx] <= cfg_i.wdata[GW-1:0];
                default: func_q[port_idx] <= cfg_i.wdata[GW*FW-1:0];
            endcase
        end
    end

    // ####################
    // read back
    // ####################

    always_comb begin
        cfg_rdata_o = '0;
        case (field)
            2'd0: cfg_rdata_o[GW-1:0] = pins_sync_i[port_idx*GW +: GW]; // live pins, not out_q
            2'd1: cfg_rdata_o[GW-1:0] = mode_q[port_idx];
            2'd2: cfg_rdata_o[GW-1:0] = otype_q[port_idx];
            default: cfg_rdata_o[GW*FW-1:0] = func_q[port_idx];
        endcase
    end

    // ####################
    // pad drive
    // ####################

    generate
        for (genvar g = 0; g < `PWR_NO_GPIOS; g++) begin : g_port
            for (genvar b = 0; b < GW; b++) begin : g_pin
                assign pads_o[g*GW+b] = '{
                    o:     out_q[g][b],
                    mode:  mode_q[g][b],
                    otype: otype_q[g][b]
                };
                assign func_o[g*GW+b] = func_q[g][b*FW +: FW]; // pin 0 in the low bits
            end
        end
    endgenerate

endmodule

`default_nettype wire

/* source/power_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "power_macros.svh"

module power_core (
    input  wire logic                                     clk_i,
    input  wire logic                                     rst_n_i,
    input  wire logic                                     pause_req_i,
    output logic                                          pause_ack_o,
    output logic [`PWR_NO_MEMS-1:0]                       mem_pause_req_o,
    input  wire logic [`PWR_NO_MEMS-1:0]                  mem_pause_ack_i,
    output logic [`PWR_NO_MEMS-1:0]                       mem_srst_o,
    input  wire power_pkg::cfg_req_t                      cfg_i,
    output logic [`PWR_CFG_DW-1:0]                        cfg_rdata_o,
    input  wire logic [`PWR_NO_PINS-1:0]                  pins_i,
    output power_pkg::io_pad_t [`PWR_NO_PINS-1:0]         pads_o,
    output logic [`PWR_NO_PINS-1:0][`PWR_FUNC_WIDTH-1:0]  func_o
);

    typedef logic [`PWR_NO_PINS-1:0] pin_vec_t;
    typedef logic [`PWR_NO_MEMS-1:0] mem_vec_t;

    pin_vec_t pins_sync;
    mem_vec_t mem_ack_sync;

    pad_sync #(.payload_t(pin_vec_t)) pin_sync (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .d_i     (pins_i),
        .q_o     (pins_sync)
    );

    pad_sync #(.payload_t(mem_vec_t)) ack_sync (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .d_i     (mem_pause_ack_i),
        .q_o     (mem_ack_sync)
    );

    pause_seq seq (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .pause_req_i     (pause_req_i),
        .mem_ack_sync_i  (mem_ack_sync),
        .mem_pause_req_o (mem_pause_req_o),
        .mem_srst_o      (mem_srst_o),
        .pause_ack_o     (pause_ack_o)
    );

    // the paused level locks the pad config
    gpio_bank gpio (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .cfg_i       (cfg_i),
        .paused_i    (pause_ack_o),
        .pins_sync_i (pins_sync),
        .pads_o      (pads_o),
        .func_o      (func_o),
        .cfg_rdata_o (cfg_rdata_o)
    );

endmodule

`default_nettype wire

/* source/power_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "power_macros.svh"

module power_top (
    input  wire logic clk_i,
    input  wire logic rst_n_i,

    input  wire logic pause_req_i,
    output logic      pause_ack_o,

    output logic [`PWR_NO_MEMS-1:0]      mem_srst_o,
    output logic [`PWR_NO_MEMS-1:0]      mem_pause_req_o,
    input  wire logic [`PWR_NO_MEMS-1:0] mem_pause_ack_i,

    input  wire logic [`PWR_NO_PINS-1:0]            gpio_i_i,
    output logic [`PWR_NO_PINS-1:0]                 gpio_o_o,
    output logic [`PWR_NO_PINS-1:0]                 gpio_mode_o,
    output logic [`PWR_NO_PINS-1:0]                 gpio_otype_o,
    output logic [`PWR_FUNC_WIDTH*`PWR_NO_PINS-1:0] gpio_func_o,

    input  wire logic                   cfg_we_i,
    input  wire logic [`PWR_CFG_AW-1:0] cfg_addr_i,
    input  wire logic [`PWR_CFG_DW-1:0] cfg_wdata_i,
    output logic [`PWR_CFG_DW-1:0]      cfg_rdata_o
);

    localparam int FW = `PWR_FUNC_WIDTH;

    power_pkg::cfg_req_t                      cfg_req;
    power_pkg::io_pad_t [`PWR_NO_PINS-1:0]    pads;
    logic [`PWR_NO_PINS-1:0][FW-1:0]          func;

    assign cfg_req = '{we: cfg_we_i, addr: cfg_addr_i, wdata: cfg_wdata_i};

    // ####################
    // pad flattening
    // ####################

    generate
        for (genvar i = 0; i < `PWR_NO_PINS; i++) begin : g_pad
            assign gpio_o_o    [i] = pads[i].o;
            assign gpio_mode_o [i] = pads[i].mode;
            assign gpio_otype_o[i] = pads[i].otype;

            assign gpio_func_o[i*FW +: FW] = func[i];
        end
    endgenerate

    power_core core (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),

        .pause_req_i (pause_req_i),
        .pause_ack_o (pause_ack_o),

        .mem_pause_req_o (mem_pause_req_o),
        .mem_pause_ack_i (mem_pause_ack_i),
        .mem_srst_o      (mem_srst_o),

        .cfg_i       (cfg_req),
        .cfg_rdata_o (cfg_rdata_o),

        .pins_i (gpio_i_i),
        .pads_o (pads),
        .func_o (func)
    );

endmodule

`default_nettype wire

/* verif/power_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "power_macros.svh"

module power_tb;

    localparam int GW      = `PWR_GPIO_WIDTH;
    localparam int FW      = `PWR_FUNC_WIDTH;
    localparam int DW      = `PWR_CFG_DW;
    localparam int TIMEOUT = 40; // cycles allowed for any single wait

    localparam logic [`PWR_NO_MEMS-1:0] ALL_MEMS = '1;

    logic                                    clk = 1'b0;
    logic                                    rst_n;
    logic                                    pause_req;
    logic                                    pause_ack;
    logic [`PWR_NO_MEMS-1:0]                 mem_srst;
    logic [`PWR_NO_MEMS-1:0]                 mem_pause_req;
    logic [`PWR_NO_MEMS-1:0]                 mem_ack = '0;
    logic [`PWR_NO_PINS-1:0]                 gpio_i;
    logic [`PWR_NO_PINS-1:0]                 gpio_o;
    logic [`PWR_NO_PINS-1:0]                 gpio_mode;
    logic [`PWR_NO_PINS-1:0]                 gpio_otype;
    logic [`PWR_FUNC_WIDTH*`PWR_NO_PINS-1:0] gpio_func;
    logic                                    cfg_we;
    logic [`PWR_CFG_AW-1:0]                  cfg_addr;
    logic [DW-1:0]                           cfg_wdata;
    logic [DW-1:0]                           cfg_rdata;

    // shadow copy of the register map
    logic [GW-1:0]    sh_out   [`PWR_NO_GPIOS];
    logic [GW-1:0]    sh_mode  [`PWR_NO_GPIOS];
    logic [GW-1:0]    sh_otype [`PWR_NO_GPIOS];
    logic [GW*FW-1:0] sh_func  [`PWR_NO_GPIOS];
    logic             paused; // set between a pause and its release

    logic [31:0]             lfsr = 32'hfefcfb3f;
    logic [`PWR_NO_MEMS-1:0] mem_busy = '0;
    logic [2:0]              mem_cnt [`PWR_NO_MEMS];

    int mismatches = 0;
    int failures   = 0;

    always #10 clk = ~clk;

    power_top DUT (
        .clk_i           (clk),
        .rst_n_i         (rst_n),
        .pause_req_i     (pause_req),
        .pause_ack_o     (pause_ack),
        .mem_srst_o      (mem_srst),
        .mem_pause_req_o (mem_pause_req),
        .mem_pause_ack_i (mem_ack),
        .gpio_i_i        (gpio_i),
        .gpio_o_o        (gpio_o),
        .gpio_mode_o     (gpio_mode),
        .gpio_otype_o    (gpio_otype),
        .gpio_func_o     (gpio_func),
        .cfg_we_i        (cfg_we),
        .cfg_addr_i      (cfg_addr),
        .cfg_wdata_i     (cfg_wdata),
        .cfg_rdata_o     (cfg_rdata)
    );

    // ####################
    // memory model
    // ####################

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32 22 2 1
    endfunction

    function automatic logic [2:0] next_delay();
        logic [2:0] v;
        v = '0;
        for (int i = 0; i < 3; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[1:0], lfsr[0]};
        end
        return (v == 3'd0) ? 3'd7 : v; // 1 to 7 cycles
    endfunction

    always @(posedge clk) begin
        #2;
        for (int m = 0; m < `PWR_NO_MEMS; m++) begin
            if (!rst_n) begin
                mem_ack[m]  = 1'b0;
                mem_busy[m] = 1'b0;
            end else if (mem_busy[m]) begin
                mem_cnt[m] = mem_cnt[m] - 3'd1;
                if (mem_cnt[m] == 3'd0) begin
                    mem_ack[m]  = mem_pause_req[m]; // answer with the current request level
                    mem_busy[m] = 1'b0;
                end
            end else if (mem_ack[m] != mem_pause_req[m]) begin
                mem_cnt[m]  = next_delay();
                mem_busy[m] = 1'b1;
            end
        end
    end

    // ####################
    // checks
    // ####################

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        assert (got === exp) else begin
            mismatches++;
            $display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_pads();
        compare_value("gpio_o_o", 32'(gpio_o), 32'({sh_out[1], sh_out[0]}));
        compare_value("gpio_mode_o", 32'(gpio_mode), 32'({sh_mode[1], sh_mode[0]}));
        compare_value("gpio_otype_o", 32'(gpio_otype), 32'({sh_otype[1], sh_otype[0]}));
        compare_value("gpio_func_o", 32'(gpio_func), 32'({sh_func[1], sh_func[0]}));
    endtask

    function automatic logic [DW-1:0] shadow_field(input logic [`PWR_CFG_AW-1:0] addr);
        logic [DW-1:0] r;
        int            port;
        r    = '0;
        port = int'(addr >> 2);
        case (addr[1:0])
            2'd1: r[GW-1:0] = sh_mode[port];
            2'd2: r[GW-1:0] = sh_otype[port];
            default: r[GW*FW-1:0] = sh_func[port];
        endcase
        return r;
    endfunction

    // ####################
    // commands
    // ####################

    task automatic write_cfg(input logic [`PWR_CFG_AW-1:0] addr, input logic [DW-1:0] data);
        int port;
        port = int'(addr >> 2);
        @(posedge clk);
        #2;
        cfg_we    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        if (!paused) begin // writes are dropped while paused
            case (addr[1:0])
                2'd0: sh_out[port] = data[GW-1:0];
                2'd1: sh_mode[port] = data[GW-1:0];
                2'd2: sh_otype[port] = data[GW-1:0];
                default: sh_func[port] = data[GW*FW-1:0];
            endcase
        end
        @(posedge clk);
        #2;
        cfg_we = 1'b0;
        @(negedge clk);
        compare_pads();
    endtask

    task automatic read_cfg(input logic [`PWR_CFG_AW-1:0] addr, input logic [DW-1:0] exp);
        int n;
        @(posedge clk);
        #2;
        cfg_addr = addr;
        @(negedge clk);
        if (addr[1:0] == 2'd0) begin
            for (n = 0; n < TIMEOUT && cfg_rdata !== exp; n++) begin
                @(negedge clk); // pins pass the synchronizer first
            end
        end else begin
            compare_value("cfg_rdata_o (shadow)", 32'(cfg_rdata), 32'(shadow_field(addr)));
        end
        compare_value("cfg_rdata_o", 32'(cfg_rdata), 32'(exp));
    endtask

    task automatic drive_pins(input logic [`PWR_NO_PINS-1:0] value);
        @(posedge clk);
        #2;
        gpio_i = value;
    endtask

    task automatic run_pause();
        int n;
        int hi_cnt;
        hi_cnt = 0;
        @(posedge clk);
        #2;
        pause_req = 1'b1;
        for (n = 0; n < TIMEOUT && !pause_ack; n++) begin
            @(negedge clk);
            hi_cnt = (&mem_ack) ? hi_cnt + 1 : 0;
            // two synchronizer stages and then the ack register
            compare_value("pause_ack_o", 32'(pause_ack), (hi_cnt > 3) ? 32'd1 : 32'd0);
        end
        assert (pause_ack) else begin
            failures++;
            $display("Timeout at %0t ns: pause_ack_o never rose after the pause request", $time);
        end
        compare_value("mem_pause_req_o", 32'(mem_pause_req), 32'(ALL_MEMS));
        paused = 1'b1;
    endtask

    task automatic release_pause();
        int n;
        int lo_cnt;
        lo_cnt = 0;
        @(posedge clk);
        #2;
        pause_req = 1'b0;
        for (n = 0; n < TIMEOUT && pause_ack; n++) begin
            @(negedge clk);
            lo_cnt = (|mem_ack) ? 0 : lo_cnt + 1;
            compare_value("pause_ack_o", 32'(pause_ack), (lo_cnt > 3) ? 32'd0 : 32'd1);
        end
        assert (!pause_ack) else begin
            failures++;
            $display("Timeout at %0t ns: pause_ack_o stayed high after the release", $time);
        end
        compare_value("mem_pause_req_o", 32'(mem_pause_req), 32'd0);
        paused = 1'b0;
    endtask

    // ####################
    // main sequence
    // ####################

    initial begin
        int          fd;
        int          c;
        int          n;
        logic [7:0]  ch;
        logic [31:0] a;
        logic [31:0] d;

        rst_n     = 1'b0;
        pause_req = 1'b0;
        gpio_i    = '0;
        cfg_we    = 1'b0;
        cfg_addr  = '0;
        cfg_wdata = '0;
        paused    = 1'b0;
        for (int p = 0; p < `PWR_NO_GPIOS; p++) begin
            sh_out[p]   = '0;
            sh_mode[p]  = '0;
            sh_otype[p] = '0;
            sh_func[p]  = '0;
        end

        repeat (15) @(posedge clk);
        @(negedge clk);
        compare_value("mem_srst_o", 32'(mem_srst), 32'(ALL_MEMS));
        @(posedge clk);
        #2;
        rst_n = 1'b1;
        n     = 0;
        while (mem_srst !== '0 && n < TIMEOUT) begin
            @(posedge clk);
            @(negedge clk);
            n++;
        end
        assert (mem_srst === '0) else begin
            failures++;
            $display("Timeout at %0t ns: mem_srst_o never fell after reset", $time);
        end
        compare_value("mem_srst_o edges after release", 32'(n), 32'(`PWR_SRST_CYCLES));
        compare_pads();
        compare_value("pause_ack_o", 32'(pause_ack), 32'd0);
        compare_value("mem_pause_req_o", 32'(mem_pause_req), 32'd0);

        fd = $fopen("verif/power_tests.txt", "r");
        if (fd == 0) begin
            failures++;
            $display("Could not open the test file verif/power_tests.txt");
        end else begin
            c = $fgetc(fd);
            while (c != -1) begin
                ch = 8'(c);
                if (ch == "#") begin
                    while (c != -1 && c != 10) begin
                        c = $fgetc(fd);
                    end
                end else if (ch == "W" || ch == "R" || ch == "I" || ch == "P" || ch == "U") begin
                    n = $fscanf(fd, " %h %h", a, d);
                    if (n != 2) begin
                        failures++;
                        $display("Test file line for command %s is not complete", ch);
                    end else begin
                        case (ch)
                            "W": write_cfg(a[`PWR_CFG_AW-1:0], d[DW-1:0]);
                            "R": read_cfg(a[`PWR_CFG_AW-1:0], d[DW-1:0]);
                            "I": drive_pins(a[`PWR_NO_PINS-1:0]);
                            "P": run_pause();
                            default: release_pause();
                        endcase
                    end
                end else if (c > 32) begin
                    failures++;
                    $display("Unknown command %s in the test file", ch);
                end
                c = $fgetc(fd);
            end
            $fclose(fd);
        end

        repeat (2) @(posedge clk);
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verif/power_tests.txt */
# cmd  field1  field2 (hex): W addr data, R addr expected, I pins 0, P 0 0, U 0 0
# addr is port * 4 + field (0 out or pins, 1 mode, 2 otype, 3 func)
W 0 00a5
W 1 00ff
W 2 000f
W 3 9c36
W 4 005a
W 5 00f0
W 6 0003
W 7 e4e4
R 1 00ff
R 2 000f
R 3 9c36
R 5 00f0
R 6 0003
R 7 e4e4
I 3cc3 0
R 0 00c3
R 4 003c
P 0 0
W 1 0011
W 4 0077
R 1 00ff
U 0 0
W 1 0011
W 4 0077
R 1 0011
I 00ff 0
R 0 00ff
R 4 0000

/* project.f */
+incdir+include
source/power_pkg.sv
source/pad_sync.sv
source/pause_seq.sv
source/gpio_bank.sv
source/power_core.sv
source/power_top.sv
verif/power_tb.sv

/* run.sh */
#!/bin/sh
# compile with Verilator, run, then look for the failure banner in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps --top-module power_tb \
    -f project.f -o power_sim \
    && ./obj_dir/power_sim > sim.log 2>&1 \
    || { echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q ">>> FAIL" sim.log && exit 1
grep -q ">>> PASS" sim.log || exit 1
exit 0
